// ==== logic/regfile_pkg.sv ====
package regfile_pkg;

	// Data path width
	localparam int xlen = 32;

	// Register index width, 64 words
	localparam int reg_addr_w = 6;

	// APB byte address width
	// Index sits in bits 7:2, anything at bit 8 or above is out of range
	localparam int apb_addr_w = 12;

	// Upper index bits that select the machine CSR group (32..39)
	localparam logic [2:0] csr_group = 3'd4;

	// Machine CSR indices
	localparam logic [reg_addr_w-1:0] csr_mcycle     = 6'd32;
	localparam logic [reg_addr_w-1:0] csr_mcycleh    = 6'd33;
	localparam logic [reg_addr_w-1:0] csr_minstret   = 6'd34;
	localparam logic [reg_addr_w-1:0] csr_minstreth  = 6'd35;
	localparam logic [reg_addr_w-1:0] csr_mtvec      = 6'd36;
	localparam logic [reg_addr_w-1:0] csr_dep_lo     = 6'd37;
	localparam logic [reg_addr_w-1:0] csr_dep_hi     = 6'd38;
	localparam logic [reg_addr_w-1:0] csr_soft_reset = 6'd39;

	// Slot within the CSR group, same order as the indices above
	typedef enum logic [2:0] {
		slot_mcycle     = 3'd0,
		slot_mcycleh    = 3'd1,
		slot_minstret   = 3'd2,
		slot_minstreth  = 3'd3,
		slot_mtvec      = 3'd4,
		slot_dep_lo     = 3'd5,
		slot_dep_hi     = 3'd6,
		slot_soft_reset = 3'd7
	} csr_slot_e;

	// Register index seen either flat or as CSR group plus slot
	typedef union packed {
		logic [reg_addr_w-1:0] flat;
		struct packed {
			logic [2:0] group_id;
			csr_slot_e  slot;
		} csr;
	} reg_addr_u;

endpackage

// ==== logic/reg_access_ctrl.sv ====
`timescale 1ns/1ps

module reg_access_ctrl import regfile_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  rd_wen,
	input  logic [reg_addr_w-1:0] rd_waddr,
	input  logic [xlen-1:0]       rd_wdata,
	input  logic [reg_addr_w-1:0] rb_raddr,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [apb_addr_w-1:0] paddr,
	input  logic [xlen-1:0]       pwdata,
	input  logic [xlen-1:0]       gpr_rb_rdata,
	input  logic [xlen-1:0]       gpr_dbg_rdata,
	input  logic [63:0]           cycle_count,
	input  logic [63:0]           instr_count,
	input  logic [xlen-1:0]       mtvec_value,
	input  logic [xlen-1:0]       dep_lo_value,
	input  logic [xlen-1:0]       dep_hi_value,
	output logic                  gpr_wen,
	output logic [reg_addr_w-1:0] wr_index,
	output logic [xlen-1:0]       wr_data,
	output logic                  cnt_wen,
	output logic                  csr_wen,
	output csr_slot_e             wr_slot,
	output logic [reg_addr_w-1:0] dbg_raddr,
	output logic [xlen-1:0]       rb_rdata,
	output logic [xlen-1:0]       prdata,
	output logic                  pready,
	output logic                  pslverr,
	output logic                  soft_reset_req
);

	reg_addr_u       wr_addr_u;
	reg_addr_u       rb_addr_u;
	reg_addr_u       dbg_addr_u;
	logic            apb_access;
	logic            addr_err;
	logic            apb_wr_grant;
	logic            merged_wen;
	logic            wr_is_csr;
	logic            rdata_phase;
	logic            rb_is_csr_r;
	logic            dbg_is_csr_r;
	logic [xlen-1:0] rb_csr_r;
	logic [xlen-1:0] dbg_csr_r;

	// CSR value at a slot, soft_reset reads as zero
	function automatic logic [xlen-1:0] csr_read(input csr_slot_e slot);
		case (slot)
			slot_mcycle:    csr_read = cycle_count[31:0];
			slot_mcycleh:   csr_read = cycle_count[63:32];
			slot_minstret:  csr_read = instr_count[31:0];
			slot_minstreth: csr_read = instr_count[63:32];
			slot_mtvec:     csr_read = mtvec_value;
			slot_dep_lo:    csr_read = dep_lo_value;
			slot_dep_hi:    csr_read = dep_hi_value;
			default:        csr_read = '0;
		endcase
	endfunction

	// Setup is psel alone, access adds penable
	assign apb_access = psel && penable;
	assign addr_err   = |paddr[apb_addr_w-1:8];

	// APB write waits for a cycle with no core write
	assign apb_wr_grant = apb_access && pwrite && !addr_err && !rd_wen;
	assign merged_wen   = rd_wen || apb_wr_grant;

	// Core write has priority on the single write path
	assign wr_addr_u  = rd_wen ? rd_waddr : paddr[7:2];
	assign wr_data    = rd_wen ? rd_wdata : pwdata;
	assign wr_index   = wr_addr_u.flat;
	assign wr_slot    = wr_addr_u.csr.slot;
	assign wr_is_csr  = (wr_addr_u.csr.group_id == csr_group);

	// Index 0 and the CSR group never reach the array
	assign gpr_wen = merged_wen && !wr_is_csr && (wr_addr_u.flat != '0);
	assign cnt_wen = merged_wen && wr_is_csr &&
		(wr_addr_u.csr.slot inside {slot_mcycle, slot_mcycleh, slot_minstret, slot_minstreth});
	assign csr_wen = merged_wen && wr_is_csr &&
		(wr_addr_u.csr.slot inside {slot_mtvec, slot_dep_lo, slot_dep_hi});

	// One-cycle request, no storage behind it
	assign soft_reset_req = merged_wen && (wr_addr_u.flat == csr_soft_reset);

	// Debug read index goes to the array straight from paddr
	assign dbg_addr_u = paddr[7:2];
	assign dbg_raddr  = dbg_addr_u.flat;
	assign rb_addr_u  = rb_raddr;

	// Read data cycle follows the first access cycle of a good read
	always_ff @(posedge clock) begin
		if (reset) begin
			rdata_phase  <= 1'b0;
			rb_is_csr_r  <= 1'b0;
			dbg_is_csr_r <= 1'b0;
		end else begin
			rdata_phase  <= apb_access && !pwrite && !addr_err && !rdata_phase;
			rb_is_csr_r  <= (rb_addr_u.csr.group_id == csr_group);
			dbg_is_csr_r <= (dbg_addr_u.csr.group_id == csr_group);
		end
	end

	// CSR values sampled alongside the array read
	always_ff @(posedge clock) begin
		rb_csr_r  <= csr_read(rb_addr_u.csr.slot);
		dbg_csr_r <= csr_read(dbg_addr_u.csr.slot);
	end

	assign rb_rdata = rb_is_csr_r ? rb_csr_r : gpr_rb_rdata;
	assign prdata   = rdata_phase ? (dbg_is_csr_r ? dbg_csr_r : gpr_dbg_rdata) : '0;

	// Error ends at once, write on grant, read one cycle later
	assign pready  = apb_access && (addr_err || (pwrite ? !rd_wen : rdata_phase));
	assign pslverr = apb_access && addr_err;

endmodule

// ==== logic/gpr_array.sv ====
`timescale 1ns/1ps

module gpr_array import regfile_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  gpr_wen,
	input  logic [reg_addr_w-1:0] wr_index,
	input  logic [xlen-1:0]       wr_data,
	input  logic [reg_addr_w-1:0] ra_raddr,
	input  logic [reg_addr_w-1:0] rb_raddr,
	input  logic [reg_addr_w-1:0] dbg_raddr,
	output logic [xlen-1:0]       ra_rdata,
	output logic [xlen-1:0]       gpr_rb_rdata,
	output logic [xlen-1:0]       gpr_dbg_rdata
);

	// Full 64-entry space, CSR slots stay zero
	logic [xlen-1:0] regs [2**reg_addr_w];

	// Cleared on reset so every read is defined
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 2**reg_addr_w; i++) begin
				regs[i] <= '0;
			end
		end else if (gpr_wen) begin
			// Control already filters index 0 and the CSR group
			regs[wr_index] <= wr_data;
		end
	end

	// Registered reads return the value before this edge's write
	always_ff @(posedge clock) begin
		ra_rdata      <= regs[ra_raddr];
		gpr_rb_rdata  <= regs[rb_raddr];
		gpr_dbg_rdata <= regs[dbg_raddr];
	end

endmodule

// ==== logic/perf_counters.sv ====
`timescale 1ns/1ps

module perf_counters import regfile_pkg::*; #(
	parameter int enable_counters = 1
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            instr_complete,
	input  logic            cnt_wen,
	input  csr_slot_e       wr_slot,
	input  logic [xlen-1:0] wr_data,
	output logic [63:0]     cycle_count,
	output logic [63:0]     instr_count
);

	if (enable_counters != 0) begin : g_counters

		// Cycle counter, half loads replace the increment
		always_ff @(posedge clock) begin
			if (reset) begin
				cycle_count <= '0;
			end else if (cnt_wen && wr_slot == slot_mcycle) begin
				cycle_count <= {cycle_count[63:32], wr_data};
			end else if (cnt_wen && wr_slot == slot_mcycleh) begin
				cycle_count <= {wr_data, cycle_count[31:0]};
			end else begin
				cycle_count <= cycle_count + 64'd1;
			end
		end

		// Retired instructions, one per completion pulse
		always_ff @(posedge clock) begin
			if (reset) begin
				instr_count <= '0;
			end else if (cnt_wen && wr_slot == slot_minstret) begin
				instr_count <= {instr_count[63:32], wr_data};
			end else if (cnt_wen && wr_slot == slot_minstreth) begin
				instr_count <= {wr_data, instr_count[31:0]};
			end else if (instr_complete) begin
				instr_count <= instr_count + 64'd1;
			end
		end

	end else begin : g_no_counters

		// Feature off, counters read zero
		assign cycle_count = '0;
		assign instr_count = '0;

	end

endmodule

// ==== logic/machine_csrs.sv ====
`timescale 1ns/1ps

module machine_csrs import regfile_pkg::*; #(
	parameter int enable_dep = 1
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            csr_wen,
	input  csr_slot_e       wr_slot,
	input  logic [xlen-1:0] wr_data,
	output logic [xlen-1:0] mtvec,
	output logic [xlen-1:0] dep_lo,
	output logic [xlen-1:0] dep_hi
);

	// Trap vector, no lock
	always_ff @(posedge clock) begin
		if (reset) begin
			mtvec <= '0;
		end else if (csr_wen && wr_slot == slot_mtvec) begin
			mtvec <= wr_data;
		end
	end

	if (enable_dep != 0) begin : g_dep

		// Bit 1 set locks a bound until the next reset
		always_ff @(posedge clock) begin
			if (reset) begin
				dep_lo <= '0;
				dep_hi <= '0;
			end else if (csr_wen) begin
				if (wr_slot == slot_dep_lo && !dep_lo[1]) begin
					dep_lo <= wr_data;
				end
				if (wr_slot == slot_dep_hi && !dep_hi[1]) begin
					dep_hi <= wr_data;
				end
			end
		end

	end else begin : g_no_dep

		// No execution protection, bounds read zero
		assign dep_lo = '0;
		assign dep_hi = '0;

	end

endmodule

// ==== logic/regfile_subsys.sv ====
`timescale 1ns/1ps

module regfile_subsys import regfile_pkg::*; #(
	parameter int enable_counters = 1,
	parameter int enable_dep      = 1
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  instr_complete,
	// Core register port
	input  logic [reg_addr_w-1:0] ra_raddr,
	output logic [xlen-1:0]       ra_rdata,
	input  logic [reg_addr_w-1:0] rb_raddr,
	output logic [xlen-1:0]       rb_rdata,
	input  logic [reg_addr_w-1:0] rd_waddr,
	input  logic [xlen-1:0]       rd_wdata,
	input  logic                  rd_wen,
	// Host debug port, APB slave
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [apb_addr_w-1:0] paddr,
	input  logic [xlen-1:0]       pwdata,
	output logic [xlen-1:0]       prdata,
	output logic                  pready,
	output logic                  pslverr,
	// Machine state seen by the core
	output logic                  soft_reset_req,
	output logic [xlen-1:0]       dep_lo,
	output logic [xlen-1:0]       dep_hi,
	output logic [xlen-1:0]       mtvec
);

	// Merged write path from control
	logic                  gpr_wen;
	logic                  cnt_wen;
	logic                  csr_wen;
	logic [reg_addr_w-1:0] wr_index;
	logic [xlen-1:0]       wr_data;
	csr_slot_e             wr_slot;
	// Read side back into control
	logic [reg_addr_w-1:0] dbg_raddr;
	logic [xlen-1:0]       gpr_rb_rdata;
	logic [xlen-1:0]       gpr_dbg_rdata;
	logic [63:0]           cycle_count;
	logic [63:0]           instr_count;

	reg_access_ctrl reg_access_ctrl_i (
		.clock          (clock),
		.reset          (reset),
		.rd_wen         (rd_wen),
		.rd_waddr       (rd_waddr),
		.rd_wdata       (rd_wdata),
		.rb_raddr       (rb_raddr),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.gpr_rb_rdata   (gpr_rb_rdata),
		.gpr_dbg_rdata  (gpr_dbg_rdata),
		.cycle_count    (cycle_count),
		.instr_count    (instr_count),
		.mtvec_value    (mtvec),
		.dep_lo_value   (dep_lo),
		.dep_hi_value   (dep_hi),
		.gpr_wen        (gpr_wen),
		.wr_index       (wr_index),
		.wr_data        (wr_data),
		.cnt_wen        (cnt_wen),
		.csr_wen        (csr_wen),
		.wr_slot        (wr_slot),
		.dbg_raddr      (dbg_raddr),
		.rb_rdata       (rb_rdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.soft_reset_req (soft_reset_req)
	);

	gpr_array gpr_array_i (
		.clock         (clock),
		.reset         (reset),
		.gpr_wen       (gpr_wen),
		.wr_index      (wr_index),
		.wr_data       (wr_data),
		.ra_raddr      (ra_raddr),
		.rb_raddr      (rb_raddr),
		.dbg_raddr     (dbg_raddr),
		.ra_rdata      (ra_rdata),
		.gpr_rb_rdata  (gpr_rb_rdata),
		.gpr_dbg_rdata (gpr_dbg_rdata)
	);

	perf_counters #(
		.enable_counters (enable_counters)
	) perf_counters_i (
		.clock          (clock),
		.reset          (reset),
		.instr_complete (instr_complete),
		.cnt_wen        (cnt_wen),
		.wr_slot        (wr_slot),
		.wr_data        (wr_data),
		.cycle_count    (cycle_count),
		.instr_count    (instr_count)
	);

	machine_csrs #(
		.enable_dep (enable_dep)
	) machine_csrs_i (
		.clock   (clock),
		.reset   (reset),
		.csr_wen (csr_wen),
		.wr_slot (wr_slot),
		.wr_data (wr_data),
		.mtvec   (mtvec),
		.dep_lo  (dep_lo),
		.dep_hi  (dep_hi)
	);

endmodule

// ==== dv/regfile_subsys_checker.sv ====
`timescale 1ns/1ps

module regfile_subsys_checker import regfile_pkg::*; (
	input logic                  clock,
	input logic                  reset,
	input logic                  psel,
	input logic                  penable,
	input logic                  pwrite,
	input logic [apb_addr_w-1:0] paddr,
	input logic                  pready,
	input logic                  pslverr,
	input logic [reg_addr_w-1:0] ra_raddr,
	input logic [xlen-1:0]       ra_rdata
);

	// Ready only in an access cycle
	ready_in_access: assert property (@(posedge clock) disable iff (reset)
		pready |-> psel && penable)
		else $error("pready outside an APB access cycle");

	// Error response always completes the transfer
	err_with_ready: assert property (@(posedge clock) disable iff (reset)
		pslverr |-> pready)
		else $error("pslverr without pready");

	// Host holds the request while the slave stalls
	req_stable: assert property (@(posedge clock) disable iff (reset)
		psel && penable && !pready |=> $stable(paddr) && $stable(pwrite))
		else $error("paddr or pwrite changed before pready");

	// Index 0 reads zero on port a
	zero_reg: assert property (@(posedge clock) disable iff (reset)
		ra_raddr == '0 |=> ra_rdata == '0)
		else $error("ra_rdata not zero after a read of index 0");

endmodule

bind regfile_subsys regfile_subsys_checker regfile_subsys_checker_i (
	.clock    (clock),
	.reset    (reset),
	.psel     (psel),
	.penable  (penable),
	.pwrite   (pwrite),
	.paddr    (paddr),
	.pready   (pready),
	.pslverr  (pslverr),
	.ra_raddr (ra_raddr),
	.ra_rdata (ra_rdata)
);

// ==== dv/regfile_subsys_tb.sv ====
`timescale 1ns/1ps

module regfile_subsys_tb import regfile_pkg::*; ();

	// Row kinds
	localparam int k_core_wr   = 0;
	localparam int k_core_rd   = 1;
	localparam int k_apb_wr    = 2;
	localparam int k_apb_rd    = 3;
	localparam int k_retire    = 4;
	localparam int k_idle      = 5;
	localparam int k_apb_bad   = 6;
	localparam int k_apb_stall = 7;
	// Core writes run here while an APB write waits
	localparam logic [5:0] busy_index = 6'd30;

	logic        clock;
	logic        reset;
	logic        instr_complete;
	logic [5:0]  ra_raddr;
	logic [5:0]  rb_raddr;
	logic [5:0]  rd_waddr;
	logic [31:0] rd_wdata;
	logic        rd_wen;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] ra_rdata;
	logic [31:0] rb_rdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        soft_reset_req;
	logic [31:0] dep_lo;
	logic [31:0] dep_hi;
	logic [31:0] mtvec;

	// Operation table
	int          row_kind [64];
	logic [5:0]  row_idx [64];
	logic [31:0] row_data [64];
	logic [31:0] row_exp [64];
	int          n_rows = 0;

	// Shadow model of the register space
	logic [31:0] gpr_m [64] = '{default: '0};
	logic [63:0] cyc_m = '0;
	logic [63:0] ins_m = '0;
	logic [31:0] mtvec_m = '0;
	logic [31:0] dep_lo_m = '0;
	logic [31:0] dep_hi_m = '0;

	int          row_errs;
	int          passed = 0;
	int          failed = 0;
	logic        timed_out = 1'b0;

	regfile_subsys #(
		.enable_counters (1),
		.enable_dep      (1)
	) regfile_subsys_i (
		.clock          (clock),
		.reset          (reset),
		.instr_complete (instr_complete),
		.ra_raddr       (ra_raddr),
		.ra_rdata       (ra_rdata),
		.rb_raddr       (rb_raddr),
		.rb_rdata       (rb_rdata),
		.rd_waddr       (rd_waddr),
		.rd_wdata       (rd_wdata),
		.rd_wen         (rd_wen),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.soft_reset_req (soft_reset_req),
		.dep_lo         (dep_lo),
		.dep_hi         (dep_hi),
		.mtvec          (mtvec)
	);

	always #2 clock = ~clock;

	function automatic logic [31:0] model_read(input logic [5:0] idx);
		case (idx)
			csr_mcycle:     model_read = cyc_m[31:0];
			csr_mcycleh:    model_read = cyc_m[63:32];
			csr_minstret:   model_read = ins_m[31:0];
			csr_minstreth:  model_read = ins_m[63:32];
			csr_mtvec:      model_read = mtvec_m;
			csr_dep_lo:     model_read = dep_lo_m;
			csr_dep_hi:     model_read = dep_hi_m;
			csr_soft_reset: model_read = '0;
			default:        model_read = gpr_m[idx];
		endcase
	endfunction

	function automatic void model_write(input logic [5:0] idx, input logic [31:0] data);
		case (idx)
			csr_mcycle:    cyc_m = {cyc_m[63:32], data};
			csr_mcycleh:   cyc_m = {data, cyc_m[31:0]};
			csr_minstret:  ins_m = {ins_m[63:32], data};
			csr_minstreth: ins_m = {data, ins_m[31:0]};
			csr_mtvec:     mtvec_m = data;
			// Bit 1 locks a bound
			csr_dep_lo:    if (!dep_lo_m[1]) dep_lo_m = data;
			csr_dep_hi:    if (!dep_hi_m[1]) dep_hi_m = data;
			csr_soft_reset: begin
			end
			default:       if (idx != 6'd0) gpr_m[idx] = data;
		endcase
	endfunction

	// Expected values and cycle count follow each row as it is added
	// Counter reads come before any APB row, so APB edges are not counted
	function automatic void add_row(input int kind, input logic [5:0] idx,
		input logic [31:0] data);
		row_kind[n_rows] = kind;
		row_idx[n_rows]  = idx;
		row_data[n_rows] = data;
		row_exp[n_rows]  = '0;
		case (kind)
			k_core_wr: begin
				model_write(idx, data);
				// A loaded cycle half skips that edge's increment
				if (idx != csr_mcycle && idx != csr_mcycleh) cyc_m = cyc_m + 64'd1;
			end
			k_core_rd: begin
				row_exp[n_rows] = model_read(idx);
				cyc_m = cyc_m + 64'd1;
			end
			k_apb_wr: model_write(idx, data);
			k_apb_stall: begin
				model_write(idx, data);
				model_write(busy_index, ~data);
			end
			k_apb_rd: row_exp[n_rows] = model_read(idx);
			k_retire: begin
				cyc_m = cyc_m + {32'd0, data};
				ins_m = ins_m + {32'd0, data};
			end
			k_idle: cyc_m = cyc_m + {32'd0, data};
			default: begin
				// Out-of-range write stores nothing
			end
		endcase
		n_rows++;
	endfunction

	function automatic string kind_name(input int kind);
		case (kind)
			k_core_wr:   kind_name = "core write";
			k_core_rd:   kind_name = "core read";
			k_apb_wr:    kind_name = "apb write";
			k_apb_rd:    kind_name = "apb read";
			k_retire:    kind_name = "retire";
			k_apb_bad:   kind_name = "apb bad address";
			k_apb_stall: kind_name = "apb write under core writes";
			default:     kind_name = "idle";
		endcase
	endfunction

	task automatic report_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		row_errs++;
	endtask

	task automatic compare_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	// Every task starts and ends 1 ns after a rising edge
	task automatic write_port(input logic [5:0] idx, input logic [31:0] data);
		rd_wen   = 1'b1;
		rd_waddr = idx;
		rd_wdata = data;
		#1;
		// Request only for the soft_reset index
		if (soft_reset_req !== (idx == csr_soft_reset))
			report_mismatch($sformatf("soft_reset_req %b on write to %0d", soft_reset_req, idx));
		@(posedge clock);
		#1;
		rd_wen = 1'b0;
	endtask

	task automatic read_ports(input logic [5:0] idx, input logic [31:0] exp);
		logic [31:0] exp_a;
		// Port a reads the array, whose CSR entries stay zero
		exp_a    = (idx >= 6'd32 && idx <= 6'd39) ? 32'd0 : exp;
		ra_raddr = idx;
		rb_raddr = idx;
		@(posedge clock);
		#1;
		compare_word("ra_rdata", ra_rdata, exp_a);
		compare_word("rb_rdata", rb_rdata, exp);
		if (idx == csr_mtvec) compare_word("mtvec", mtvec, exp);
		if (idx == csr_dep_lo) compare_word("dep_lo", dep_lo, exp);
		if (idx == csr_dep_hi) compare_word("dep_hi", dep_hi, exp);
	endtask

	task automatic idle_cycles(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			#1;
			if (soft_reset_req !== 1'b0) report_mismatch("soft_reset_req high with no write");
			@(posedge clock);
			#1;
		end
	endtask

	task automatic pulse_retire(input int pulses);
		instr_complete = 1'b1;
		repeat (pulses) begin
			@(posedge clock);
			#1;
		end
		instr_complete = 1'b0;
	endtask

	// One APB transfer, with core writes to busy_index in the first busy cycles
	task automatic apb_transfer(input logic wr, input logic [11:0] addr,
		input logic [31:0] wdata, input int busy,
		output logic err, output logic [31:0] rdata);
		int   left;
		int   waited;
		logic done;
		left     = busy;
		waited   = 0;
		done     = 1'b0;
		err      = 1'b0;
		rdata    = '0;
		psel     = 1'b1;
		penable  = 1'b0;
		pwrite   = wr;
		paddr    = addr;
		pwdata   = wdata;
		rd_waddr = busy_index;
		rd_wdata = ~wdata;
		rd_wen   = (left > 0);
		if (left > 0) left--;
		@(posedge clock);
		#1;
		penable = 1'b1;
		while (!done && waited < 20) begin
			rd_wen = (left > 0);
			if (left > 0) left--;
			#1;
			if (pready) begin
				done  = 1'b1;
				err   = pslverr;
				rdata = prdata;
				if (rd_wen && wr) report_mismatch("pready while a core write is in progress");
			end
			@(posedge clock);
			#1;
			waited++;
		end
		psel    = 1'b0;
		penable = 1'b0;
		rd_wen  = 1'b0;
		if (!done) begin
			$display("Timeout: pready not seen within 20 cycles at %0t ns", $time);
			row_errs++;
			timed_out = 1'b1;
		end
	endtask

	task automatic apply_row(input int r);
		logic [11:0] addr;
		logic        err;
		logic [31:0] rdata;
		// Bit 8 set puts the address out of range
		addr = {(row_kind[r] == k_apb_bad) ? 4'h1 : 4'h0, row_idx[r], 2'b00};
		case (row_kind[r])
			k_core_wr: write_port(row_idx[r], row_data[r]);
			k_core_rd: read_ports(row_idx[r], row_exp[r]);
			k_retire:  pulse_retire(row_data[r]);
			k_idle:    idle_cycles(row_data[r]);
			k_apb_rd: begin
				apb_transfer(1'b0, addr, '0, 0, err, rdata);
				if (err) report_mismatch("pslverr on an in-range read");
				compare_word("prdata", rdata, row_exp[r]);
			end
			default: begin
				apb_transfer(1'b1, addr, row_data[r], (row_kind[r] == k_apb_stall) ? 3 : 0,
					err, rdata);
				if (err !== (row_kind[r] == k_apb_bad))
					report_mismatch($sformatf("pslverr %b on write", err));
			end
		endcase
	endtask

	initial begin
		void'($urandom(95));
		clock          = 1'b0;
		reset          = 1'b1;
		instr_complete = 1'b0;
		ra_raddr       = '0;
		rb_raddr       = '0;
		rd_waddr       = '0;
		rd_wdata       = '0;
		rd_wen         = 1'b0;
		psel           = 1'b0;
		penable        = 1'b0;
		pwrite         = 1'b0;
		paddr          = '0;
		pwdata         = '0;

		// General registers, index 0 and soft_reset
		add_row(k_core_wr, 6'd5, $urandom());
		add_row(k_core_rd, 6'd5, '0);
		add_row(k_core_wr, 6'd17, $urandom());
		add_row(k_core_wr, 6'd31, $urandom());
		add_row(k_core_rd, 6'd17, '0);
		add_row(k_core_rd, 6'd31, '0);
		add_row(k_core_wr, 6'd0, $urandom());
		add_row(k_core_rd, 6'd0, '0);
		add_row(k_core_wr, csr_soft_reset, $urandom());
		add_row(k_idle, 6'd0, 32'd2);
		add_row(k_core_rd, csr_soft_reset, '0);
		// Cycle and retired-instruction counters
		add_row(k_core_wr, csr_mcycle, $urandom());
		add_row(k_idle, 6'd0, 32'd5);
		add_row(k_core_rd, csr_mcycle, '0);
		add_row(k_core_wr, csr_mcycleh, $urandom());
		add_row(k_core_rd, csr_mcycleh, '0);
		add_row(k_core_wr, csr_minstret, $urandom());
		add_row(k_retire, 6'd0, 32'd4);
		add_row(k_core_rd, csr_minstret, '0);
		add_row(k_core_rd, csr_minstreth, '0);
		// DEP lock and mtvec
		add_row(k_core_wr, csr_dep_lo, $urandom() | 32'h2);
		add_row(k_core_rd, csr_dep_lo, '0);
		add_row(k_core_wr, csr_dep_lo, $urandom());
		add_row(k_core_rd, csr_dep_lo, '0);
		add_row(k_core_wr, csr_dep_hi, $urandom() & ~32'h2);
		add_row(k_core_wr, csr_dep_hi, $urandom());
		add_row(k_core_rd, csr_dep_hi, '0);
		add_row(k_core_wr, csr_mtvec, $urandom());
		add_row(k_core_rd, csr_mtvec, '0);
		add_row(k_core_wr, csr_mtvec, $urandom());
		add_row(k_core_rd, csr_mtvec, '0);
		// APB host port
		add_row(k_apb_wr, 6'd12, $urandom());
		add_row(k_core_rd, 6'd12, '0);
		add_row(k_apb_rd, csr_mtvec, '0);
		add_row(k_apb_rd, 6'd5, '0);
		add_row(k_apb_bad, 6'd12, $urandom());
		add_row(k_core_rd, 6'd12, '0);
		add_row(k_apb_stall, 6'd25, $urandom());
		add_row(k_core_rd, 6'd25, '0);
		add_row(k_core_rd, busy_index, '0);

		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;

		for (int r = 0; r < n_rows && !timed_out; r++) begin
			row_errs = 0;
			apply_row(r);
			if (row_errs == 0) begin
				passed++;
				$display("test %0d %s index %0d passed", r, kind_name(row_kind[r]), row_idx[r]);
			end else begin
				failed++;
				$display("test %0d %s index %0d failed", r, kind_name(row_kind[r]), row_idx[r]);
			end
		end

		$display("tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
		if (failed == 0 && !timed_out) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
logic/regfile_pkg.sv
logic/reg_access_ctrl.sv
logic/gpr_array.sv
logic/perf_counters.sv
logic/machine_csrs.sv
logic/regfile_subsys.sv
dv/regfile_subsys_checker.sv
dv/regfile_subsys_tb.sv

// ==== Makefile ====
# Verilator simulation of the register subsystem

VERILATOR ?= verilator
TOP       ?= regfile_subsys_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG  := Simulation completed successfully

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
